// File: tb.f
+incdir+logic
+incdir+tests
logic/fwdDataPkg.sv
logic/fwdCtrlPkg.sv
logic/resultBus.sv
logic/forwardSlot.sv
logic/issueHandshake.sv
logic/forwardUnit.sv
tests/tbForwardUnit.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the forward unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
  -f tb.f --top-module tbForwardUnit -o VtbForwardUnit
./obj_dir/VtbForwardUnit 2>&1 | tee sim.log

if ! grep -q "TESTBENCH PASSED" sim.log; then
  echo "simulation did not pass, see sim.log"
  exit 1
fi

// File: tests/tbVectors.svh
/*
  Stimulus table for the forward unit testbench:
  expected source codes, row types and the rows,
  long holds mark the back-pressure rows
*/
localparam logic [1:0] srcCur = 2'd0;  // unit result in capture cycle
localparam logic [1:0] srcPrev = 2'd1; // unit result one cycle earlier
localparam logic [1:0] srcOld = 2'd2;  // old data from the RS
localparam logic [3:0] selNone = 4'(`FWD_SEL_NONE);

typedef struct packed {
  logic [3:0] fuSel;
  logic [3:0] fuuSel;
  logic narrow;
  logic [1:0] src; // expected source
  logic [63:0] oldData;
} opVector;

typedef struct packed {
  opVector a; // source operand 0
  opVector b; // source operand 1
  logic [7:0] holdCycles; // outAck delay in cycles
} vecRow;

localparam int numVectors = 12;

// per operand: fuSel, fuuSel, narrow, expected source, oldData; then outAck delay
localparam vecRow vectorTable [numVectors] = '{
  '{'{4'd0, selNone, 1'b0, srcCur, 64'h1111_2222_3333_4444},
    '{4'd9, selNone, 1'b0, srcCur, 64'h5555_6666_7777_8888}, 8'd2},
  '{'{selNone, 4'd3, 1'b0, srcPrev, 64'h0123_4567_89ab_cdef},
    '{selNone, 4'd7, 1'b0, srcPrev, 64'hfedc_ba98_7654_3210}, 8'd3},
  '{'{selNone, selNone, 1'b0, srcOld, 64'hdead_beef_cafe_f00d},
    '{selNone, selNone, 1'b0, srcOld, 64'h8000_0000_0000_0001}, 8'd1},
  '{'{4'd5, selNone, 1'b1, srcCur, 64'h2222_3333_4444_5555},
    '{selNone, 4'd2, 1'b1, srcPrev, 64'h6666_7777_8888_9999}, 8'd4},
  '{'{selNone, selNone, 1'b1, srcOld, 64'hffff_0000_abcd_1234},
    '{4'd1, selNone, 1'b0, srcCur, 64'h0f0f_0f0f_0f0f_0f0f}, 8'd2},
  '{'{selNone, 4'd0, 1'b0, srcPrev, 64'h1357_9bdf_2468_ace0},
    '{selNone, selNone, 1'b1, srcOld, 64'hc001_d00d_7777_0000}, 8'd0},
  '{'{4'd4, selNone, 1'b0, srcCur, 64'h0000_0001_0000_0002},
    '{selNone, 4'd9, 1'b1, srcPrev, 64'h4444_0000_4444_0000}, 8'd40},
  '{'{4'd9, selNone, 1'b1, srcCur, 64'h9999_8888_7777_6666},
    '{selNone, 4'd5, 1'b0, srcPrev, 64'h5a5a_5a5a_a5a5_a5a5}, 8'd1},
  '{'{selNone, selNone, 1'b0, srcOld, 64'h7fff_ffff_ffff_fffe},
    '{4'd2, selNone, 1'b1, srcCur, 64'h3c3c_3c3c_c3c3_c3c3}, 8'd25},
  '{'{selNone, 4'd8, 1'b0, srcPrev, 64'hbeef_0000_0000_beef},
    '{4'd6, selNone, 1'b0, srcCur, 64'h0101_0101_1010_1010}, 8'd3},
  '{'{4'd3, selNone, 1'b0, srcCur, 64'h6789_abcd_ef01_2345},
    '{selNone, 4'd1, 1'b0, srcPrev, 64'h1000_2000_3000_4000}, 8'd2},
  '{'{selNone, selNone, 1'b1, srcOld, 64'hffff_ffff_ffff_ffff},
    '{selNone, selNone, 1'b0, srcOld, 64'h0000_0000_0000_0000}, 8'd1}
};

// File: tests/tbForwardUnit.sv
/*
  Testbench for the operand forward unit:
  clock and reset, LCG driven FU results with a two-cycle history,
  table driven four-phase issue sequence, operand and
  back-pressure checks
*/
`timescale 1ns/100ps
`include "fwd_consts.svh"

module tbForwardUnit
  import fwdDataPkg::*;
  import fwdCtrlPkg::*;
();

  `include "tbVectors.svh"

  localparam int waitLimit = 200;   // cycles per handshake wait
  localparam int preRaiseHold = 20; // long holds also queue the next request
  localparam int sigInAck = 0;
  localparam int sigOutReq = 1;

  logic clk;
  logic rst;
  fuResultVec fuResults;
  logic inReq;
  operandReqVec reqs;
  logic inAck;
  operandVec operands;
  logic outReq;
  logic outAck;

  logic [31:0] lcgState;
  fuResultVec curDriven;  // on the bus now
  fuResultVec prevDriven; // on the bus one cycle before
  fuResultVec edgeCur;    // as seen at the last rising edge
  fuResultVec edgePrev;

  forwardUnit UUT (
    .clk(clk),
    .rst(rst),
    .fuResults(fuResults),
    .inReq(inReq),
    .reqs(reqs),
    .inAck(inAck),
    .operands(operands),
    .outReq(outReq),
    .outAck(outAck)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // fresh result on every unit, shortly after each edge
  initial begin
    lcgState = 32'h5263782e;
    curDriven = '0;
    prevDriven = '0;
    edgeCur = '0;
    edgePrev = '0;
    fuResults = '0;
    forever begin
      @(posedge clk);
      edgeCur = curDriven;
      edgePrev = prevDriven;
      #0.5;
      prevDriven = curDriven;
      for (int u = 0; u < `FWD_NUM_FU; u++) begin
        lcgState = lcgNext(lcgState);
        curDriven[u].half.hi = lcgState;
        lcgState = lcgNext(lcgState);
        curDriven[u].half.lo = lcgState;
      end
      fuResults = curDriven;
    end
  end

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic checkValue(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
    if (got !== exp) begin
      abortRun($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic stepCycle();
    @(posedge clk);
    #0.5;
  endtask

  function automatic logic probe(input int sigId);
    return (sigId == sigInAck) ? inAck : outReq;
  endfunction

  task automatic waitLevel(input int sigId, input logic level, input string what);
    int cycles;
    cycles = 0;
    while (probe(sigId) !== level) begin
      if (cycles == waitLimit) begin
        abortRun({"timeout while waiting for ", what});
      end
      stepCycle();
      cycles++;
    end
  endtask

  function automatic opVector rowOp(input vecRow r, input int i);
    return (i == 0) ? r.a : r.b;
  endfunction

  // reference pick by the expected-source column
  function automatic operandWord expectedOperand(input opVector o,
      input fuResultVec cur, input fuResultVec prev);
    operandWord v;
    v = '0;
    case (o.src)
      srcCur: v = cur[o.fuSel];
      srcPrev: v = prev[o.fuuSel];
      default: v.full = o.oldData;
    endcase
    if (o.narrow) begin
      v.half.hi = '0;
    end
    return v;
  endfunction

  task automatic driveRow(input vecRow r);
    opVector o;
    for (int i = 0; i < `FWD_NUM_OPS; i++) begin
      o = rowOp(r, i);
      reqs[i].sel.fuSel = o.fuSel;
      reqs[i].sel.fuuSel = o.fuuSel;
      reqs[i].oldData = o.oldData;
      reqs[i].narrow = o.narrow;
    end
  endtask

  task automatic checkOperands(input operandVec exp);
    for (int i = 0; i < `FWD_NUM_OPS; i++) begin
      checkValue($sformatf("operands[%0d]", i), operands[i].full, exp[i].full);
    end
  endtask

  initial begin
    operandVec expVec;
    vecRow r;
    opVector o;
    logic queued;
    rst = 1'b1;
    inReq = 1'b0;
    outAck = 1'b0;
    reqs = '0;
    queued = 1'b0;
    repeat (10) @(posedge clk);
    #0.5;
    rst = 1'b0;
    checkValue("inAck", 64'(inAck), 64'd0);
    checkValue("outReq", 64'(outReq), 64'd0);
    checkOperands('0);

    for (int n = 0; n < numVectors; n++) begin
      r = vectorTable[n];
      if (!queued) begin
        driveRow(r);
        inReq = 1'b1;
      end
      queued = 1'b0;
      waitLevel(sigInAck, 1'b1, "inAck to rise");
      // capture happened at the edge just before inAck showed up
      for (int i = 0; i < `FWD_NUM_OPS; i++) begin
        o = rowOp(r, i);
        if (o.src == srcPrev && edgeCur[o.fuuSel] == edgePrev[o.fuuSel]) begin
          abortRun("current and previous result of the selected unit are equal");
        end
        expVec[i] = expectedOperand(o, edgeCur, edgePrev);
      end
      inReq = 1'b0;
      waitLevel(sigInAck, 1'b0, "inAck to fall");
      waitLevel(sigOutReq, 1'b1, "outReq to rise");
      checkOperands(expVec);

      for (int k = 0; k < int'(r.holdCycles); k++) begin
        stepCycle();
        if (k == 2 && int'(r.holdCycles) >= preRaiseHold && n + 1 < numVectors) begin
          driveRow(vectorTable[n + 1]); // next request waits behind the output
          inReq = 1'b1;
          queued = 1'b1;
        end
        checkOperands(expVec);
        checkValue("outReq", 64'(outReq), 64'd1);
        checkValue("inAck", 64'(inAck), 64'd0);
      end

      outAck = 1'b1;
      waitLevel(sigOutReq, 1'b0, "outReq to fall");
      outAck = 1'b0;
    end

    stepCycle();
    checkValue("inAck", 64'(inAck), 64'd0);
    checkValue("outReq", 64'(outReq), 64'd0);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: logic/forwardUnit.sv
/*
  Operand write-forward stage top level:
  result bus delay stage, one forward slot per
  source operand and the issue handshake sequencer
*/
`timescale 1ns/100ps
`include "fwd_consts.svh"

module forwardUnit
  import fwdDataPkg::*;
  import fwdCtrlPkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  fuResultVec   fuResults,
  input  logic         inReq,
  input  operandReqVec reqs,
  output logic         inAck,
  output operandVec    operands,
  output logic         outReq,
  input  logic         outAck
);

  fuResultVec prevResults;
  logic capture;

  resultBus feeder (
    .clk(clk),
    .rst(rst),
    .fuResults(fuResults),
    .prevResults(prevResults)
  );

  // all sources of an instruction share one capture strobe
  for (genvar i = 0; i < `FWD_NUM_OPS; i++) begin : genSlot
    forwardSlot slot (
      .clk(clk),
      .rst(rst),
      .capture(capture),
      .req(reqs[i]),
      .fuResults(fuResults),
      .prevResults(prevResults),
      .opData(operands[i])
    );
  end

  issueHandshake drain (
    .clk(clk),
    .rst(rst),
    .inReq(inReq),
    .inAck(inAck),
    .outReq(outReq),
    .outAck(outAck),
    .capture(capture)
  );

endmodule

// File: logic/issueHandshake.sv
/*
  Issue handshake sequencer:
  four-phase req/ack on the instruction input and
  on the operand output, capture strobe for the
  forward slots, back-pressure from the output side,
  protocol checks
*/
`timescale 1ns/100ps

module issueHandshake (
  input  logic clk,
  input  logic rst,
  input  logic inReq,
  output logic inAck,
  output logic outReq,
  input  logic outAck,
  output logic capture
);

  logic inIdle;
  logic outIdle;

  assign inIdle = !inAck;
  assign outIdle = !outReq && !outAck; // consumer done with last operands

  // new request, previous one answered and output drained
  assign capture = inReq && inIdle && outIdle;

  // input side, ack follows capture, drops after req is gone
  always_ff @(posedge clk) begin
    if (rst) begin
      inAck <= 1'b0;
    end else if (capture) begin
      inAck <= 1'b1;
    end else if (inAck && !inReq) begin
      inAck <= 1'b0;
    end
  end

  // output side, operands valid from capture until ack
  always_ff @(posedge clk) begin
    if (rst) begin
      outReq <= 1'b0;
    end else if (capture) begin
      outReq <= 1'b1;
    end else if (outReq && outAck) begin
      outReq <= 1'b0;
    end
  end

  outReqHeld: assert property (@(posedge clk) disable iff (rst)
    $fell(outReq) |-> $past(outAck))
    else $error("outReq dropped before outAck was seen");

endmodule

// File: logic/forwardSlot.sv
/*
  Forward slot for one source operand:
  current and previous cycle selector decode,
  three-way source pick with narrow zero-extension,
  capture register held outside capture,
  selector legality checks
*/
`timescale 1ns/100ps
`include "fwd_consts.svh"

module forwardSlot
  import fwdDataPkg::*;
  import fwdCtrlPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       capture,
  input  operandReq  req,
  input  fuResultVec fuResults,
  input  fuResultVec prevResults,
  output operandWord opData
);

  operandWord curVal;
  operandWord prevVal;
  operandWord selVal;
  operandWord nextVal;
  logic fuHit;
  logic fuuHit;

  assign fuHit = req.sel.fuSel != fuCode'(`FWD_SEL_NONE);
  assign fuuHit = req.sel.fuuSel != fuCode'(`FWD_SEL_NONE);

  // one decoder per level, unused codes give zero
  always_comb begin
    curVal = '0;
    prevVal = '0;
    for (int u = 0; u < `FWD_NUM_FU; u++) begin
      if (req.sel.fuSel == fuCode'(u)) begin
        curVal = fuResults[u];
      end
      if (req.sel.fuuSel == fuCode'(u)) begin
        prevVal = prevResults[u];
      end
    end
  end

  always_comb begin
    if (fuHit) begin
      selVal = curVal;
    end else if (fuuHit) begin
      selVal = prevVal;
    end else begin
      selVal.full = req.oldData; // both levels say keep old
    end
    nextVal = selVal;
    if (req.narrow) begin
      nextVal.half.hi = '0; // 32 bit op, zero extend
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      opData <= '0;
    end else if (capture) begin
      opData <= nextVal;
    end
  end

  // selectors arrive from the RS, capture from the handshake
  selLegal: assert property (@(posedge clk) disable iff (rst)
    capture |-> (req.sel.fuSel < fuCode'(`FWD_NUM_FU) || !fuHit) &&
                (req.sel.fuuSel < fuCode'(`FWD_NUM_FU) || !fuuHit))
    else $error("forward selector outside 0..9 and 15 at capture");

  oneSource: assert property (@(posedge clk) disable iff (rst)
    capture |-> !(fuHit && fuuHit))
    else $error("current and previous cycle forward both requested");

endmodule

// File: logic/resultBus.sv
/*
  Result bus delay stage:
  keeps a one-cycle-late copy of every FU result,
  read by the previous-cycle forward selector
*/
`timescale 1ns/100ps
`include "fwd_consts.svh"

module resultBus
  import fwdDataPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  fuResultVec fuResults,
  output fuResultVec prevResults
);

  // one bank per unit so each sits next to its FU
  for (genvar u = 0; u < `FWD_NUM_FU; u++) begin : genBank
    always_ff @(posedge clk) begin
      if (rst) begin
        prevResults[u] <= '0;
      end else begin
        prevResults[u] <= fuResults[u]; // no stall, fixed 1 cycle
      end
    end
  end

endmodule

// File: logic/fwdCtrlPkg.sv
/*
  Control types of the forward stage:
  FU selector code, the two-level forward selector
  and the per-operand request with old data and
  narrow flag
*/
`include "fwd_consts.svh"

package fwdCtrlPkg;

  // unit number 0..9, or the all-ones keep-old code
  typedef logic [`FWD_SEL_WIDTH-1:0] fuCode;

  typedef struct packed {
    fuCode fuSel;  // unit driving in the capture cycle
    fuCode fuuSel; // unit that drove one cycle before
  } fwdSel;

  // one source operand as sent by the reservation station
  typedef struct packed {
    fwdSel sel;
    logic [`FWD_DATA_WIDTH-1:0] oldData; // value already held in the RS
    logic narrow;                        // clear upper half after select
  } operandReq;

  typedef operandReq [`FWD_NUM_OPS-1:0] operandReqVec;

endpackage

// File: logic/fwdDataPkg.sv
/*
  Data path types of the forward stage:
  operand word with full and hi/lo half views,
  FU result vector and per-instruction operand vector
*/
`include "fwd_consts.svh"

package fwdDataPkg;

  typedef struct packed {
    logic [`FWD_HALF_WIDTH-1:0] hi;
    logic [`FWD_HALF_WIDTH-1:0] lo;
  } halfWords;

  // one 64 bit operand, read whole or as two halves
  typedef union packed {
    logic [`FWD_DATA_WIDTH-1:0] full;
    halfWords half; // narrow path writes these separately
  } operandWord;

  // results driven by every FU in one cycle
  typedef operandWord [`FWD_NUM_FU-1:0] fuResultVec;

  // captured source operands of one instruction
  typedef operandWord [`FWD_NUM_OPS-1:0] operandVec;

endpackage

// File: logic/fwd_consts.svh
/*
  Width and count constants for the operand forward stage:
  operand width and half width, number of functional units,
  source operands per instruction, selector width and the
  no-forward selector code
*/
`ifndef FWD_CONSTS_SVH
`define FWD_CONSTS_SVH

`define FWD_DATA_WIDTH 64
`define FWD_HALF_WIDTH 32

`define FWD_NUM_FU 10 // units 0..9 on the result bus
`define FWD_NUM_OPS 2 // sources per issuing instruction

`define FWD_SEL_WIDTH 4
// all-ones selector, take nothing from this level
`define FWD_SEL_NONE 15

`endif
